/* Makefile */
# Verilator build and run of the SoC slice testbench

VERILATOR ?= verilator
TOP       ?= soc_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= TESTBENCH FAILED
PASS_MSG  ?= TESTBENCH PASSED

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* common/soc_pkg.sv */
// Shared address map, widths and bus payload types of the SoC slice.
// Every access is a single beat, with no IDs, bursts or atomics.
// The address region field is 12 bits, so each target window sits in one 1 MiB region.
// periph_bytes must be a power of two.

package soc_pkg;

  // widths
  localparam int unsigned soc_addr_w    = 32;
  localparam int unsigned soc_data_w    = 128;
  localparam int unsigned soc_strb_w    = soc_data_w / 8;
  localparam int unsigned periph_data_w = 64;
  localparam int unsigned periph_strb_w = periph_data_w / 8;

  // address split used by the bus decoder
  localparam int unsigned soc_region_w = 12;
  localparam int unsigned soc_offset_w = soc_addr_w - soc_region_w;

  // address map
  localparam logic [soc_addr_w-1:0] l2_base     = 32'h1C00_0000;
  localparam logic [soc_addr_w-1:0] periph_base = 32'h1A10_0000;
  localparam int unsigned           periph_bytes = 4096;
  localparam int unsigned           periph_off_w = $clog2(periph_bytes);

  // peripheral register file
  localparam int unsigned periph_n_regs = 8;
  // JTAG identification code, read back through register 0
  localparam logic [periph_data_w-1:0] periph_idcode = 64'h0000_0000_2495_11C3;

  typedef struct packed {
    logic [soc_region_w-1:0] region;
    logic [soc_offset_w-1:0] offset;
  } soc_addr_fields_t;

  // raw byte address for the targets, region/offset view for the decoder
  typedef union packed {
    logic [soc_addr_w-1:0] raw;
    soc_addr_fields_t      field;
  } soc_addr_u;

  // 177 bits
  typedef struct packed {
    soc_addr_u               addr;
    logic                    we;
    logic [soc_data_w-1:0]   wdata;
    logic [soc_strb_w-1:0]   strb;
  } soc_req_t;

  // 129 bits
  typedef struct packed {
    logic [soc_data_w-1:0] rdata;
    logic                  err;
  } soc_rsp_t;

  // 85 bits
  typedef struct packed {
    logic [periph_off_w-1:0]  offset;
    logic                     we;
    logic [periph_data_w-1:0] wdata;
    logic [periph_strb_w-1:0] strb;
  } periph_req_t;

  // 65 bits
  typedef struct packed {
    logic [periph_data_w-1:0] rdata;
    logic                     err;
  } periph_rsp_t;

endpackage

/* files.f */
common/soc_pkg.sv
soc_bus/soc_bus_demux.sv
l2_mem/l2_mem.sv
periph/periph_dwc.sv
periph/periph_regs.sv
hdl/soc_top.sv
sim/tb_clk_gen.sv
sim/soc_checker.sv
sim/soc_tb.sv

/* hdl/soc_top.sv */
// SoC slice top: host port into the bus, L2 memory and the peripheral path.
// One transaction in flight; the response follows acceptance by exactly one cycle.
// L2_BYTES must be a power of two and no larger than one address region (1 MiB).

`timescale 1ns/1ps

module soc_top #(
  parameter int unsigned L2_BYTES = 16384
) (
  input  logic              clk_i,
  input  logic              rst_i,

  input  soc_pkg::soc_req_t host_req_i,
  input  logic              host_req_valid_i,
  output logic              host_req_ready_o,
  output soc_pkg::soc_rsp_t host_rsp_o,
  output logic              host_rsp_valid_o,
  input  logic              host_rsp_ready_i
);

  // bus to L2
  soc_pkg::soc_req_t l2_req;
  logic              l2_req_valid;
  logic              l2_req_ready;
  soc_pkg::soc_rsp_t l2_rsp;
  logic              l2_rsp_valid;
  logic              l2_rsp_ready;

  // bus to width converter
  soc_pkg::soc_req_t pp_req;
  logic              pp_req_valid;
  logic              pp_req_ready;
  soc_pkg::soc_rsp_t pp_rsp;
  logic              pp_rsp_valid;
  logic              pp_rsp_ready;

  // width converter to register file
  soc_pkg::periph_req_t narrow_req;
  logic                 narrow_req_valid;
  logic                 narrow_req_ready;
  soc_pkg::periph_rsp_t narrow_rsp;
  logic                 narrow_rsp_valid;
  logic                 narrow_rsp_ready;

  soc_bus_demux #(
    .L2_BYTES (L2_BYTES)
  ) i_soc_bus (
    .clk_i,
    .rst_i,
    .host_req_i,
    .host_req_valid_i,
    .host_req_ready_o,
    .host_rsp_o,
    .host_rsp_valid_o,
    .host_rsp_ready_i,
    .l2_req_o       (l2_req),
    .l2_req_valid_o (l2_req_valid),
    .l2_req_ready_i (l2_req_ready),
    .l2_rsp_i       (l2_rsp),
    .l2_rsp_valid_i (l2_rsp_valid),
    .l2_rsp_ready_o (l2_rsp_ready),
    .pp_req_o       (pp_req),
    .pp_req_valid_o (pp_req_valid),
    .pp_req_ready_i (pp_req_ready),
    .pp_rsp_i       (pp_rsp),
    .pp_rsp_valid_i (pp_rsp_valid),
    .pp_rsp_ready_o (pp_rsp_ready)
  );

  l2_mem #(
    .L2_BYTES (L2_BYTES)
  ) i_l2_mem (
    .clk_i,
    .rst_i,
    .req_i       (l2_req),
    .req_valid_i (l2_req_valid),
    .req_ready_o (l2_req_ready),
    .rsp_o       (l2_rsp),
    .rsp_valid_o (l2_rsp_valid),
    .rsp_ready_i (l2_rsp_ready)
  );

  periph_dwc i_dwc_periph (
    .clk_i,
    .rst_i,
    .wide_req_i         (pp_req),
    .wide_req_valid_i   (pp_req_valid),
    .wide_req_ready_o   (pp_req_ready),
    .wide_rsp_o         (pp_rsp),
    .wide_rsp_valid_o   (pp_rsp_valid),
    .wide_rsp_ready_i   (pp_rsp_ready),
    .narrow_req_o       (narrow_req),
    .narrow_req_valid_o (narrow_req_valid),
    .narrow_req_ready_i (narrow_req_ready),
    .narrow_rsp_i       (narrow_rsp),
    .narrow_rsp_valid_i (narrow_rsp_valid),
    .narrow_rsp_ready_o (narrow_rsp_ready)
  );

  periph_regs i_periph_regs (
    .clk_i,
    .rst_i,
    .req_i       (narrow_req),
    .req_valid_i (narrow_req_valid),
    .req_ready_o (narrow_req_ready),
    .rsp_o       (narrow_rsp),
    .rsp_valid_o (narrow_rsp_valid),
    .rsp_ready_i (narrow_rsp_ready)
  );

endmodule

/* l2_mem/l2_mem.sv */
// L2 memory of 128-bit words with byte-strobe writes.
// Addresses wrap modulo L2_BYTES, which must be a power of two of at least 32.
// A write answers with the merged word. Content is undefined after reset.
// Response is registered one cycle after acceptance and held until taken.

`timescale 1ns/1ps

module l2_mem #(
  parameter int unsigned L2_BYTES = 16384
) (
  input  logic              clk_i,
  input  logic              rst_i,

  input  soc_pkg::soc_req_t req_i,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  output soc_pkg::soc_rsp_t rsp_o,
  output logic              rsp_valid_o,
  input  logic              rsp_ready_i
);

  localparam int unsigned dw      = soc_pkg::soc_data_w;
  localparam int unsigned sw      = soc_pkg::soc_strb_w;
  localparam int unsigned word_lsb = $clog2(sw);
  localparam int unsigned n_words = L2_BYTES / sw;
  localparam int unsigned idx_w   = $clog2(n_words);

  logic [dw-1:0]    mem [n_words];
  logic [idx_w-1:0] idx;
  logic [dw-1:0]    cur_word;
  logic [dw-1:0]    wr_word;
  logic [dw-1:0]    rdata_q;
  logic             rsp_valid_q;
  logic             accept;

  // word index, upper address bits dropped
  assign idx      = req_i.addr.raw[word_lsb +: idx_w];
  assign cur_word = mem[idx];

  always_comb begin
    for (int b = 0; b < sw; b++) begin
      wr_word[b*8 +: 8] = req_i.strb[b] ? req_i.wdata[b*8 +: 8] : cur_word[b*8 +: 8];
    end
  end

  assign req_ready_o = ~rsp_valid_q;
  assign accept      = req_valid_i & req_ready_o;

  always_ff @(posedge clk_i) begin
    if (accept) begin
      if (req_i.we) begin
        mem[idx] <= wr_word;
      end
      rdata_q <= req_i.we ? wr_word : cur_word;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_valid_q <= 1'b0;
    end else if (accept) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  assign rsp_o.rdata = rdata_q;
  assign rsp_o.err   = 1'b0;
  assign rsp_valid_o = rsp_valid_q;

endmodule

/* periph/periph_dwc.sv */
// Narrows single-beat 128-bit requests to the 64-bit peripheral bus.
// Address bit 3 picks the half; the offset keeps the bits below periph_bytes.
// Only the half select is stored, so latency equals the register file's.

`timescale 1ns/1ps

module periph_dwc (
  input  logic                 clk_i,
  input  logic                 rst_i,

  input  soc_pkg::soc_req_t    wide_req_i,
  input  logic                 wide_req_valid_i,
  output logic                 wide_req_ready_o,
  output soc_pkg::soc_rsp_t    wide_rsp_o,
  output logic                 wide_rsp_valid_o,
  input  logic                 wide_rsp_ready_i,

  output soc_pkg::periph_req_t narrow_req_o,
  output logic                 narrow_req_valid_o,
  input  logic                 narrow_req_ready_i,
  input  soc_pkg::periph_rsp_t narrow_rsp_i,
  input  logic                 narrow_rsp_valid_i,
  output logic                 narrow_rsp_ready_o
);

  localparam int unsigned ndw     = soc_pkg::periph_data_w;
  localparam int unsigned nsw     = soc_pkg::periph_strb_w;
  localparam int unsigned half_bit = $clog2(nsw);

  logic hi;
  logic hi_q;

  assign hi = wide_req_i.addr.raw[half_bit];

  // request side
  assign narrow_req_o.offset = wide_req_i.addr.raw[soc_pkg::periph_off_w-1:0];
  assign narrow_req_o.we     = wide_req_i.we;
  assign narrow_req_o.wdata  = hi ? wide_req_i.wdata[ndw +: ndw] : wide_req_i.wdata[0 +: ndw];
  assign narrow_req_o.strb   = hi ? wide_req_i.strb[nsw +: nsw] : wide_req_i.strb[0 +: nsw];
  assign narrow_req_valid_o  = wide_req_valid_i;
  assign wide_req_ready_o    = narrow_req_ready_i;

  // remember the half until the response comes back
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      hi_q <= 1'b0;
    end else if (wide_req_valid_i && narrow_req_ready_i) begin
      hi_q <= hi;
    end
  end

  // response side, unused half reads zero
  assign wide_rsp_o.rdata   = hi_q ? {narrow_rsp_i.rdata, {ndw{1'b0}}}
                                   : {{ndw{1'b0}}, narrow_rsp_i.rdata};
  assign wide_rsp_o.err     = narrow_rsp_i.err;
  assign wide_rsp_valid_o   = narrow_rsp_valid_i;
  assign narrow_rsp_ready_o = wide_rsp_ready_i;

endmodule

/* periph/periph_regs.sv */
// Peripheral register file on the 64-bit bus.
// Register 0 is the read-only ID code; registers 1 to 7 are byte-writable scratch.
// Offsets from 64 up answer with an error and zero data.
// Response is registered one cycle after acceptance and held until taken.

`timescale 1ns/1ps

module periph_regs (
  input  logic                 clk_i,
  input  logic                 rst_i,

  input  soc_pkg::periph_req_t req_i,
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  output soc_pkg::periph_rsp_t rsp_o,
  output logic                 rsp_valid_o,
  input  logic                 rsp_ready_i
);

  localparam int unsigned dw      = soc_pkg::periph_data_w;
  localparam int unsigned sw      = soc_pkg::periph_strb_w;
  localparam int unsigned n_regs  = soc_pkg::periph_n_regs;
  localparam int unsigned off_w   = soc_pkg::periph_off_w;
  localparam int unsigned reg_lsb = $clog2(sw);
  localparam int unsigned reg_w   = $clog2(n_regs);
  localparam logic [off_w-1:0] regs_bytes = off_w'(n_regs * sw);

  logic [dw-1:0]    regs_q [1:n_regs-1];
  logic [reg_w-1:0] reg_idx;
  logic             in_range;
  logic [dw-1:0]    cur_word;
  logic [dw-1:0]    wr_word;
  logic [dw-1:0]    rd_next;
  logic [dw-1:0]    rdata_q;
  logic             err_q;
  logic             rsp_valid_q;
  logic             accept;

  assign reg_idx  = req_i.offset[reg_lsb +: reg_w];
  assign in_range = req_i.offset < regs_bytes;

  always_comb begin
    cur_word = soc_pkg::periph_idcode;
    for (int i = 1; i < n_regs; i++) begin
      if (reg_idx == reg_w'(i)) begin
        cur_word = regs_q[i];
      end
    end
  end

  always_comb begin
    for (int b = 0; b < sw; b++) begin
      wr_word[b*8 +: 8] = req_i.strb[b] ? req_i.wdata[b*8 +: 8] : cur_word[b*8 +: 8];
    end
  end

  // reads return the register after the write, ID writes are dropped
  always_comb begin
    if (!in_range) begin
      rd_next = '0;
    end else if (req_i.we && reg_idx != '0) begin
      rd_next = wr_word;
    end else begin
      rd_next = cur_word;
    end
  end

  assign req_ready_o = ~rsp_valid_q;
  assign accept      = req_valid_i & req_ready_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_valid_q <= 1'b0;
      for (int i = 1; i < n_regs; i++) begin
        regs_q[i] <= '0;
      end
    end else begin
      if (accept) begin
        rsp_valid_q <= 1'b1;
      end else if (rsp_ready_i) begin
        rsp_valid_q <= 1'b0;
      end
      for (int i = 1; i < n_regs; i++) begin
        if (accept && req_i.we && in_range && reg_idx == reg_w'(i)) begin
          regs_q[i] <= wr_word;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rdata_q <= rd_next;
      err_q   <= ~in_range;
    end
  end

  assign rsp_o.rdata = rdata_q;
  assign rsp_o.err   = err_q;
  assign rsp_valid_o = rsp_valid_q;

endmodule

/* sim/soc_checker.sv */
// Concurrent checks on the host port of soc_top, attached with bind.
// Assumes the host keeps request valid low while reset is high.

`timescale 1ns/1ps

module soc_checker (
  input logic              clk_i,
  input logic              rst_i,
  input logic              host_req_valid_i,
  input logic              host_req_ready_o,
  input soc_pkg::soc_rsp_t host_rsp_o,
  input logic              host_rsp_valid_o,
  input logic              host_rsp_ready_i
);

  logic accept;
  logic pending_q;

  assign accept = host_req_valid_i & host_req_ready_o;

  // set at acceptance, cleared when the response transfers
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pending_q <= 1'b0;
    end else if (accept) begin
      pending_q <= 1'b1;
    end else if (host_rsp_valid_o && host_rsp_ready_i) begin
      pending_q <= 1'b0;
    end
  end

  rsp_one_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
    accept |=> host_rsp_valid_o)
    else $error("host response not valid one cycle after acceptance");

  no_accept_pending: assert property (@(posedge clk_i) disable iff (rst_i)
    pending_q |-> !host_req_ready_o)
    else $error("request ready high while a response is pending");

  rsp_held: assert property (@(posedge clk_i) disable iff (rst_i)
    (host_rsp_valid_o && !host_rsp_ready_i) |=> (host_rsp_valid_o && $stable(host_rsp_o)))
    else $error("host response dropped or changed under back-pressure");

  quiet_in_reset: assert property (@(posedge clk_i)
    rst_i |=> (!host_rsp_valid_o && !host_req_ready_o))
    else $error("host valid or ready high during reset");

endmodule

bind soc_top soc_checker i_soc_checker (
  .clk_i            (clk_i),
  .rst_i            (rst_i),
  .host_req_valid_i (host_req_valid_i),
  .host_req_ready_o (host_req_ready_o),
  .host_rsp_o       (host_rsp_o),
  .host_rsp_valid_o (host_rsp_valid_o),
  .host_rsp_ready_i (host_rsp_ready_i)
);

/* sim/soc_tb.sv */
// Testbench of the SoC slice: a directed table, then random L2 traffic.
// Inputs change 2 ns after the rising edge, outputs are sampled on the falling edge.
// L2 content is undefined after reset, so random reads only touch words already written.

`timescale 1ns/1ps

module soc_tb;

  localparam int unsigned l2_bytes    = 16384;
  localparam int unsigned drive_dly   = 2;
  localparam int unsigned timeout_cyc = 50;
  localparam int unsigned n_random    = 200;
  localparam int unsigned n_ref_words = 64;

  typedef struct packed {
    logic [2:0]   test_id;
    logic [31:0]  addr;
    logic         we;
    logic [127:0] wdata;
    logic [15:0]  strb;
    logic [127:0] exp_rdata;
    logic         exp_err;
  } vec_t;

  logic              clk;
  logic              rst;
  soc_pkg::soc_req_t host_req;
  logic              host_req_valid;
  logic              host_req_ready;
  soc_pkg::soc_rsp_t host_rsp;
  logic              host_rsp_valid;
  logic              host_rsp_ready;

  vec_t         vec_q [$];
  vec_t         rnd_q [$];
  logic [31:0]  rng_state;
  logic [127:0] ref_mem   [n_ref_words];
  logic         ref_valid [n_ref_words];
  int unsigned  checks;
  int unsigned  errors;
  logic         aborted;

  tb_clk_gen #(
    .PERIOD_NS  (40),
    .RST_CYCLES (3)
  ) i_clk_gen (
    .clk_o (clk),
    .rst_o (rst)
  );

  soc_top #(
    .L2_BYTES (l2_bytes)
  ) DUT (
    .clk_i            (clk),
    .rst_i            (rst),
    .host_req_i       (host_req),
    .host_req_valid_i (host_req_valid),
    .host_req_ready_o (host_req_ready),
    .host_rsp_o       (host_rsp),
    .host_rsp_valid_o (host_rsp_valid),
    .host_rsp_ready_i (host_rsp_ready)
  );

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = lcg_step(rng_state);
    return rng_state;
  endfunction

  // response ready about three cycles out of four
  function automatic logic pick_ready();
    logic [31:0] r;
    r = next_rand();
    return r[31:30] != 2'b00;
  endfunction

  function automatic logic [127:0] merge_bytes(input logic [127:0] old_word,
                                               input logic [127:0] new_word,
                                               input logic [15:0]  strb);
    logic [127:0] res;
    res = old_word;
    for (int b = 0; b < 16; b++) begin
      if (strb[b]) begin
        res[b*8 +: 8] = new_word[b*8 +: 8];
      end
    end
    return res;
  endfunction

  function automatic string test_title(input int t);
    case (t)
      1:       return "L2 write and read-back";
      2:       return "ID register";
      3:       return "scratch register, upper half";
      4:       return "error responses";
      default: return "random L2 traffic";
    endcase
  endfunction

  function automatic void add_vec(input logic [2:0] id, input logic [31:0] addr,
                                  input logic we, input logic [127:0] wdata,
                                  input logic [15:0] strb, input logic [127:0] exp_rdata,
                                  input logic exp_err);
    vec_q.push_back('{id, addr, we, wdata, strb, exp_rdata, exp_err});
  endfunction

  task automatic load_table();
    logic [31:0]  l2a;
    logic [31:0]  ppa;
    logic [127:0] id_word;
    l2a     = soc_pkg::l2_base + 32'h20;
    ppa     = soc_pkg::periph_base;
    id_word = {64'h0, soc_pkg::periph_idcode};
    // full write, then bytes 0-3 and 12-15 replaced
    add_vec(3'd1, l2a, 1'b1, 128'h0011_2233_4455_6677_8899_aabb_ccdd_eeff, 16'hffff,
            128'h0011_2233_4455_6677_8899_aabb_ccdd_eeff, 1'b0);
    add_vec(3'd1, l2a, 1'b1, 128'h1234_5678_9abc_def0_0fed_cba9_8765_4321, 16'hf00f,
            128'h1234_5678_4455_6677_8899_aabb_8765_4321, 1'b0);
    add_vec(3'd1, l2a, 1'b0, '0, 16'h0000,
            128'h1234_5678_4455_6677_8899_aabb_8765_4321, 1'b0);
    add_vec(3'd2, ppa, 1'b0, '0, 16'h0000, id_word, 1'b0);
    add_vec(3'd2, ppa, 1'b1, {128{1'b1}}, 16'hffff, id_word, 1'b0);
    add_vec(3'd2, ppa, 1'b0, '0, 16'h0000, id_word, 1'b0);
    // register 1 sits at offset 8, so only the upper half is used
    add_vec(3'd3, ppa + 32'h8, 1'b1, {64'h0123_4567_89ab_cdef, 64'hffff_ffff_ffff_ffff},
            16'hffff, {64'h0123_4567_89ab_cdef, 64'h0}, 1'b0);
    add_vec(3'd3, ppa + 32'h8, 1'b1, {64'haaaa_bbbb_cccc_dddd, 64'h5555_5555_5555_5555},
            16'h0300, {64'h0123_4567_89ab_dddd, 64'h0}, 1'b0);
    add_vec(3'd3, ppa + 32'h8, 1'b0, '0, 16'h0000, {64'h0123_4567_89ab_dddd, 64'h0}, 1'b0);
    add_vec(3'd4, 32'h0000_1000, 1'b0, '0, 16'h0000, '0, 1'b1);
    add_vec(3'd4, 32'h3000_0000, 1'b1, {128{1'b1}}, 16'hffff, '0, 1'b1);
    add_vec(3'd4, ppa + 32'h40, 1'b0, '0, 16'h0000, '0, 1'b1);
    add_vec(3'd4, ppa + 32'hff8, 1'b1, {128{1'b1}}, 16'hffff, '0, 1'b1);
    add_vec(3'd4, soc_pkg::l2_base + l2_bytes, 1'b0, '0, 16'h0000, '0, 1'b1);
    add_vec(3'd4, soc_pkg::l2_base + 32'h000f_fff0, 1'b0, '0, 16'h0000, '0, 1'b1);
  endtask

  function automatic void check_rsp(input string what, input logic [31:0] addr,
                                    input soc_pkg::soc_rsp_t rsp,
                                    input logic [127:0] exp_rdata, input logic exp_err);
    checks++;
    if (rsp.rdata !== exp_rdata) begin
      $display("MISMATCH at %0t: %s, addr %h read data %h, expected %h",
               $time, what, addr, rsp.rdata, exp_rdata);
      errors++;
    end
    if (rsp.err !== exp_err) begin
      $display("MISMATCH at %0t: %s, addr %h error flag %b, expected %b",
               $time, what, addr, rsp.err, exp_err);
      errors++;
    end
  endfunction

  // a request held on the port must wait while a response is pending
  function automatic void check_blocked(input logic [31:0] addr);
    if (host_req_valid && host_req_ready) begin
      $display("MISMATCH at %0t: request accepted while the response for addr %h is pending",
               $time, addr);
      errors++;
    end
  endfunction

  // one single-beat access, with the latency and back-pressure checks
  task automatic run_access(input logic [31:0] addr, input logic we,
                            input logic [127:0] wdata, input logic [15:0] strb,
                            input logic rand_ready, input logic has_next,
                            input vec_t next_v, output soc_pkg::soc_rsp_t rsp);
    int unsigned       wait_cyc;
    logic              held;
    soc_pkg::soc_rsp_t first_rsp;
    rsp = '0;
    if (aborted) begin
      return;
    end
    // a request left on the port by the previous access is already driven
    if (!host_req_valid) begin
      @(posedge clk);
      #drive_dly;
      host_req.addr.raw = addr;
      host_req.we       = we;
      host_req.wdata    = wdata;
      host_req.strb     = strb;
      host_req_valid    = 1'b1;
      host_rsp_ready    = 1'b0;
    end
    wait_cyc = 0;
    @(negedge clk);
    while (!host_req_ready) begin
      if (wait_cyc == timeout_cyc) begin
        $display("ERROR: request to %h not accepted within %0d cycles", addr, timeout_cyc);
        errors++;
        aborted        = 1'b1;
        host_req_valid = 1'b0;
        return;
      end
      wait_cyc++;
      @(negedge clk);
    end
    // request transfers on this edge
    @(posedge clk);
    #drive_dly;
    if (has_next) begin
      host_req.addr.raw = next_v.addr;
      host_req.we       = next_v.we;
      host_req.wdata    = next_v.wdata;
      host_req.strb     = next_v.strb;
    end
    host_req_valid = has_next;
    host_rsp_ready = rand_ready ? pick_ready() : 1'b1;
    @(negedge clk);
    if (!host_rsp_valid) begin
      $display("MISMATCH at %0t: no response one cycle after accepting addr %h", $time, addr);
      errors++;
    end
    check_blocked(addr);
    held      = host_rsp_valid;
    first_rsp = host_rsp;
    wait_cyc  = 0;
    while (!(host_rsp_valid && host_rsp_ready)) begin
      if (wait_cyc == timeout_cyc) begin
        $display("ERROR: no response for addr %h within %0d cycles", addr, timeout_cyc);
        errors++;
        aborted        = 1'b1;
        host_req_valid = 1'b0;
        host_rsp_ready = 1'b0;
        return;
      end
      wait_cyc++;
      @(posedge clk);
      #drive_dly;
      host_rsp_ready = rand_ready ? pick_ready() : 1'b1;
      @(negedge clk);
      check_blocked(addr);
      if (held && (!host_rsp_valid || host_rsp !== first_rsp)) begin
        $display("MISMATCH at %0t: response for addr %h changed under back-pressure",
                 $time, addr);
        errors++;
      end
      if (!held && host_rsp_valid) begin
        held      = 1'b1;
        first_rsp = host_rsp;
      end
    end
    rsp = host_rsp;
    @(posedge clk);
    #drive_dly;
    host_rsp_ready = 1'b0;
  endtask

  initial begin : main
    soc_pkg::soc_rsp_t rsp;
    vec_t              v;
    vec_t              nxt;
    logic              has_next;
    int unsigned       wait_cyc;
    int unsigned       err_start;
    int unsigned       chk_start;
    logic [31:0]       r;
    logic [31:0]       r2;
    logic [5:0]        idx;
    logic [31:0]       addr;
    logic              we;
    logic [127:0]      wdata;
    logic [15:0]       strb;
    logic [127:0]      old_word;
    logic [127:0]      exp_rdata;

    host_req       = '0;
    host_req_valid = 1'b0;
    host_rsp_ready = 1'b0;
    rng_state      = 32'hf7c4;
    checks         = 0;
    errors         = 0;
    aborted        = 1'b0;
    for (int i = 0; i < n_ref_words; i++) begin
      ref_valid[i] = 1'b0;
      ref_mem[i]   = '0;
    end
    load_table();

    wait_cyc = 0;
    @(negedge clk);
    while (rst !== 1'b0 && !aborted) begin
      if (wait_cyc == timeout_cyc) begin
        $display("ERROR: reset still asserted after %0d cycles", timeout_cyc);
        errors++;
        aborted = 1'b1;
      end
      wait_cyc++;
      @(negedge clk);
    end

    // directed table, grouped by test
    for (int t = 1; t <= 4; t++) begin
      err_start = errors;
      chk_start = checks;
      foreach (vec_q[i]) begin
        v = vec_q[i];
        if (v.test_id == 3'(t) && !aborted) begin
          run_access(v.addr, v.we, v.wdata, v.strb, 1'b0, 1'b0, '0, rsp);
          if (!aborted) begin
            check_rsp(test_title(t), v.addr, rsp, v.exp_rdata, v.exp_err);
          end
        end
      end
      $display("test %0d, %s: %0d checks, %0d errors",
               t, test_title(t), checks - chk_start, errors - err_start);
    end

    // random L2 traffic, expected values from the reference model in issue order
    for (int n = 0; n < n_random; n++) begin
      r    = next_rand();
      idx  = r[29:24];
      addr = soc_pkg::l2_base + {22'h0, idx, r[23:20]};
      we   = r[31] || !ref_valid[idx];
      r2   = next_rand();
      if (!ref_valid[idx]) begin
        strb = 16'hffff;
      end else if (we) begin
        strb = r2[31:16];
      end else begin
        strb = 16'h0000;
      end
      wdata = '0;
      if (we) begin
        for (int k = 0; k < 4; k++) begin
          wdata[k*32 +: 32] = next_rand();
        end
      end
      if (ref_valid[idx]) begin
        old_word = ref_mem[idx];
      end else begin
        old_word = '0;
      end
      exp_rdata = we ? merge_bytes(old_word, wdata, strb) : old_word;
      if (we) begin
        ref_mem[idx]   = exp_rdata;
        ref_valid[idx] = 1'b1;
      end
      rnd_q.push_back('{3'd5, addr, we, wdata, strb, exp_rdata, 1'b0});
    end

    // the next request waits on the port while the current response is pending
    err_start = errors;
    chk_start = checks;
    foreach (rnd_q[n]) begin
      if (!aborted) begin
        v        = rnd_q[n];
        has_next = (n + 1 < rnd_q.size());
        if (has_next) begin
          nxt = rnd_q[n + 1];
        end else begin
          nxt = '0;
        end
        run_access(v.addr, v.we, v.wdata, v.strb, 1'b1, has_next, nxt, rsp);
        if (!aborted) begin
          check_rsp(test_title(5), v.addr, rsp, v.exp_rdata, v.exp_err);
        end
      end
    end
    $display("test 5, %s: %0d checks, %0d errors",
             test_title(5), checks - chk_start, errors - err_start);

    $display("tests: 5, checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* sim/tb_clk_gen.sv */
// Testbench clock and reset source.
// Reset is synchronous, active high, and released on a rising edge.

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned PERIOD_NS  = 40,
  parameter int unsigned RST_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

/* soc_bus/soc_bus_demux.sv */
// Single-master bus decoder with one transaction in flight.
// L2 claims its region up to L2_BYTES, the peripheral path claims its whole region.
// Anything else is accepted at once and answered with an error and zero data.
// Request ready waits for request valid, so it is low while the host is idle.

`timescale 1ns/1ps

module soc_bus_demux #(
  parameter int unsigned L2_BYTES = 16384
) (
  input  logic              clk_i,
  input  logic              rst_i,

  input  soc_pkg::soc_req_t host_req_i,
  input  logic              host_req_valid_i,
  output logic              host_req_ready_o,
  output soc_pkg::soc_rsp_t host_rsp_o,
  output logic              host_rsp_valid_o,
  input  logic              host_rsp_ready_i,

  output soc_pkg::soc_req_t l2_req_o,
  output logic              l2_req_valid_o,
  input  logic              l2_req_ready_i,
  input  soc_pkg::soc_rsp_t l2_rsp_i,
  input  logic              l2_rsp_valid_i,
  output logic              l2_rsp_ready_o,

  output soc_pkg::soc_req_t pp_req_o,
  output logic              pp_req_valid_o,
  input  logic              pp_req_ready_i,
  input  soc_pkg::soc_rsp_t pp_rsp_i,
  input  logic              pp_rsp_valid_i,
  output logic              pp_rsp_ready_o
);

  localparam int unsigned rw  = soc_pkg::soc_region_w;
  localparam int unsigned msb = soc_pkg::soc_addr_w - 1;
  localparam logic [rw-1:0] l2_region = soc_pkg::l2_base[msb -: rw];
  localparam logic [rw-1:0] pp_region = soc_pkg::periph_base[msb -: rw];

  // target encodings
  localparam logic [1:0] sel_none = 2'd0;
  localparam logic [1:0] sel_l2   = 2'd1;
  localparam logic [1:0] sel_pp   = 2'd2;

  logic       busy_q;
  logic [1:0] sel_q;
  logic [1:0] sel_d;
  logic       idle;
  logic       hit_l2;
  logic       hit_pp;
  logic       tgt_ready;
  logic       accept;
  logic       rsp_done;

  // address decode
  assign hit_l2 = (host_req_i.addr.field.region == l2_region) &&
                  (32'(host_req_i.addr.field.offset) < L2_BYTES);
  assign hit_pp = (host_req_i.addr.field.region == pp_region);

  always_comb begin
    if (hit_l2) begin
      sel_d = sel_l2;
    end else if (hit_pp) begin
      sel_d = sel_pp;
    end else begin
      sel_d = sel_none;
    end
  end

  assign idle = ~busy_q;

  // payload goes to both targets, only valid is steered
  assign l2_req_o       = host_req_i;
  assign pp_req_o       = host_req_i;
  assign l2_req_valid_o = host_req_valid_i & idle & (sel_d == sel_l2);
  assign pp_req_valid_o = host_req_valid_i & idle & (sel_d == sel_pp);

  always_comb begin
    case (sel_d)
      sel_l2:  tgt_ready = l2_req_ready_i;
      sel_pp:  tgt_ready = pp_req_ready_i;
      default: tgt_ready = 1'b1;
    endcase
  end

  assign host_req_ready_o = host_req_valid_i & idle & tgt_ready;
  assign accept           = host_req_valid_i & host_req_ready_o;

  // response routing by the target latched at acceptance
  always_comb begin
    host_rsp_o.rdata = '0;
    host_rsp_o.err   = 1'b1;
    host_rsp_valid_o = busy_q;
    l2_rsp_ready_o   = 1'b0;
    pp_rsp_ready_o   = 1'b0;
    case (sel_q)
      sel_l2: begin
        host_rsp_o       = l2_rsp_i;
        host_rsp_valid_o = busy_q & l2_rsp_valid_i;
        l2_rsp_ready_o   = busy_q & host_rsp_ready_i;
      end
      sel_pp: begin
        host_rsp_o       = pp_rsp_i;
        host_rsp_valid_o = busy_q & pp_rsp_valid_i;
        pp_rsp_ready_o   = busy_q & host_rsp_ready_i;
      end
      default: begin
        // decode error, answered from here
      end
    endcase
  end

  assign rsp_done = host_rsp_valid_o & host_rsp_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q <= 1'b0;
      sel_q  <= sel_none;
    end else if (accept) begin
      busy_q <= 1'b1;
      sel_q  <= sel_d;
    end else if (rsp_done) begin
      busy_q <= 1'b0;
    end
  end

endmodule
